/* rtl/ibuf_pkg.sv */
package ibuf_pkg;

    //////////////////////////////////////////////////////////////////////
    // field and index types
    //////////////////////////////////////////////////////////////////////

    // instruction address
    typedef logic [31:0] pc_t;
    // raw instruction word
    typedef logic [31:0] inst_t;
    // branch type bits plus predicted pc
    typedef logic [33:0] brinfo_t;
    // exception code from fetch
    typedef logic [7:0]  ecode_t;
    // one bit per slot, slot 1 in the msb
    typedef logic [1:0]  slot_valid_t;
    // queue entry index
    typedef logic [3:0]  ptr_t;
    // occupancy 0..16
    typedef logic [4:0]  count_t;
    // slots moved per cycle 0..2
    typedef logic [1:0]  slot_cnt_t;

    //////////////////////////////////////////////////////////////////////
    // sizing and codes
    //////////////////////////////////////////////////////////////////////

    localparam int IBUF_DEPTH  = 16;
    // free entries left when almost-full rises
    localparam int FULL_MARGIN = 6;

    // 01 is illegal on both sides
    localparam slot_valid_t VALID_BOTH  = 2'b11;
    localparam slot_valid_t VALID_FIRST = 2'b10;
    localparam slot_valid_t VALID_NONE  = 2'b00;

    // circular index step, wraps at the buffer depth
    function automatic ptr_t ptr_advance(ptr_t ptr, slot_cnt_t step);
        count_t sum;
        sum = count_t'(ptr) + count_t'(step);
        if (sum >= count_t'(IBUF_DEPTH)) begin
            sum = sum - count_t'(IBUF_DEPTH);
        end
        return ptr_t'(sum);
    endfunction

endpackage

/* rtl/ibuf_enqueue.sv */
`timescale 1ns/1ps

module ibuf_enqueue import ibuf_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  slot_valid_t i_is_valid,
    input  logic        i_flush,
    output logic        o_wr_en1,
    output logic        o_wr_en2,
    output ptr_t        o_wr_addr1,
    output ptr_t        o_wr_addr2,
    output slot_cnt_t   o_push_cnt
);

    // next free entry
    ptr_t head;

    //////////////////////////////////////////////////////////////////////
    // slot code decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        o_wr_en1   = 1'b0;
        o_wr_en2   = 1'b0;
        o_push_cnt = 2'd0;
        // slots offered in a flush cycle are dropped
        if (!i_flush) begin
            case (i_is_valid)
                VALID_BOTH: begin
                    o_wr_en1   = 1'b1;
                    o_wr_en2   = 1'b1;
                    o_push_cnt = 2'd2;
                end
                VALID_FIRST: begin
                    o_wr_en1   = 1'b1;
                    o_push_cnt = 2'd1;
                end
                default: begin
                    // none, or the illegal 01
                    o_push_cnt = 2'd0;
                end
            endcase
        end
    end

    // lane 2 lands right behind lane 1
    assign o_wr_addr1 = head;
    assign o_wr_addr2 = ptr_advance(head, 2'd1);

    // head pointer
    always_ff @(posedge clk) begin
        if (!rstn || i_flush) begin
            head <= '0;
        end else begin
            head <= ptr_advance(head, o_push_cnt);
        end
    end

    // fetch never offers slot 2 alone
    a_legal_slot_code: assert property (@(posedge clk) disable iff (!rstn)
        !i_flush |-> i_is_valid != 2'b01)
        else $error("enqueue: illegal slot code 01");

endmodule

/* rtl/ibuf_storage.sv */
`timescale 1ns/1ps

module ibuf_storage import ibuf_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      i_flush,
    // write lanes
    input  logic      i_wr_en1,
    input  logic      i_wr_en2,
    input  ptr_t      i_wr_addr1,
    input  ptr_t      i_wr_addr2,
    input  pc_t       i_pc1,
    input  inst_t     i_ir1,
    input  brinfo_t   i_brinfo1,
    input  ecode_t    i_ecode1,
    input  pc_t       i_pc2,
    input  inst_t     i_ir2,
    input  brinfo_t   i_brinfo2,
    input  ecode_t    i_ecode2,
    // occupancy updates
    input  slot_cnt_t i_push_cnt,
    input  slot_cnt_t i_pop_cnt,
    // read lanes
    input  ptr_t      i_rd_addr1,
    input  ptr_t      i_rd_addr2,
    output pc_t       o_rd_pc1,
    output inst_t     o_rd_ir1,
    output brinfo_t   o_rd_brinfo1,
    output ecode_t    o_rd_ecode1,
    output pc_t       o_rd_pc2,
    output inst_t     o_rd_ir2,
    output brinfo_t   o_rd_brinfo2,
    output ecode_t    o_rd_ecode2,
    output count_t    o_count,
    output logic      o_is_full
);

    // one array per field
    pc_t     pc_mem     [IBUF_DEPTH];
    inst_t   ir_mem     [IBUF_DEPTH];
    brinfo_t brinfo_mem [IBUF_DEPTH];
    ecode_t  ecode_mem  [IBUF_DEPTH];

    count_t  count_nxt;

    //////////////////////////////////////////////////////////////////////
    // entry storage
    //////////////////////////////////////////////////////////////////////

    // lane addresses never collide, enqueue hands out consecutive entries
    always_ff @(posedge clk) begin
        if (i_wr_en1) begin
            pc_mem[i_wr_addr1]     <= i_pc1;
            ir_mem[i_wr_addr1]     <= i_ir1;
            brinfo_mem[i_wr_addr1] <= i_brinfo1;
            ecode_mem[i_wr_addr1]  <= i_ecode1;
        end
        if (i_wr_en2) begin
            pc_mem[i_wr_addr2]     <= i_pc2;
            ir_mem[i_wr_addr2]     <= i_ir2;
            brinfo_mem[i_wr_addr2] <= i_brinfo2;
            ecode_mem[i_wr_addr2]  <= i_ecode2;
        end
    end

    // async read of the two oldest entries
    assign o_rd_pc1     = pc_mem[i_rd_addr1];
    assign o_rd_ir1     = ir_mem[i_rd_addr1];
    assign o_rd_brinfo1 = brinfo_mem[i_rd_addr1];
    assign o_rd_ecode1  = ecode_mem[i_rd_addr1];
    assign o_rd_pc2     = pc_mem[i_rd_addr2];
    assign o_rd_ir2     = ir_mem[i_rd_addr2];
    assign o_rd_brinfo2 = brinfo_mem[i_rd_addr2];
    assign o_rd_ecode2  = ecode_mem[i_rd_addr2];

    //////////////////////////////////////////////////////////////////////
    // occupancy and almost-full
    //////////////////////////////////////////////////////////////////////

    assign count_nxt = o_count + count_t'(i_push_cnt) - count_t'(i_pop_cnt);

    always_ff @(posedge clk) begin
        if (!rstn || i_flush) begin
            o_count   <= '0;
            o_is_full <= 1'b0;
        end else begin
            o_count   <= count_nxt;
            // flag built from the next count so it lines up with o_count
            o_is_full <= count_nxt >= count_t'(IBUF_DEPTH - FULL_MARGIN);
        end
    end

    // fetch honours o_is_full, so the queue never overflows
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        !i_flush |-> count_nxt <= count_t'(IBUF_DEPTH))
        else $error("storage: occupancy above depth");

    // dequeue only takes what is already stored
    a_pop_le_count: assert property (@(posedge clk) disable iff (!rstn)
        count_t'(i_pop_cnt) <= o_count)
        else $error("storage: pop larger than count");

endmodule

/* rtl/ibuf_dequeue.sv */
`timescale 1ns/1ps

module ibuf_dequeue import ibuf_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_flush,
    input  logic        i_stall,
    input  count_t      i_count,
    // oldest two entries from storage
    input  pc_t         i_rd_pc1,
    input  inst_t       i_rd_ir1,
    input  brinfo_t     i_rd_brinfo1,
    input  ecode_t      i_rd_ecode1,
    input  pc_t         i_rd_pc2,
    input  inst_t       i_rd_ir2,
    input  brinfo_t     i_rd_brinfo2,
    input  ecode_t      i_rd_ecode2,
    output ptr_t        o_rd_addr1,
    output ptr_t        o_rd_addr2,
    output slot_cnt_t   o_pop_cnt,
    // issue side
    output pc_t         o_pc1,
    output inst_t       o_ir1,
    output brinfo_t     o_brinfo1,
    output ecode_t      o_ecode1,
    output pc_t         o_pc2,
    output inst_t       o_ir2,
    output brinfo_t     o_brinfo2,
    output ecode_t      o_ecode2,
    output slot_valid_t o_is_valid
);

    // oldest stored entry
    ptr_t tail;

    //////////////////////////////////////////////////////////////////////
    // pop decision and tail
    //////////////////////////////////////////////////////////////////////

    // min(count, 2) unless held or flushed
    always_comb begin
        if (i_flush || i_stall) begin
            o_pop_cnt = 2'd0;
        end else if (i_count >= count_t'(2)) begin
            o_pop_cnt = 2'd2;
        end else begin
            o_pop_cnt = slot_cnt_t'(i_count);
        end
    end

    assign o_rd_addr1 = tail;
    assign o_rd_addr2 = ptr_advance(tail, 2'd1);

    always_ff @(posedge clk) begin
        if (!rstn || i_flush) begin
            tail <= '0;
        end else begin
            tail <= ptr_advance(tail, o_pop_cnt);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output registers
    //////////////////////////////////////////////////////////////////////

    // data hold whenever a lane is not popped
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_pc1     <= '0;
            o_ir1     <= '0;
            o_brinfo1 <= '0;
            o_ecode1  <= '0;
            o_pc2     <= '0;
            o_ir2     <= '0;
            o_brinfo2 <= '0;
            o_ecode2  <= '0;
        end else begin
            if (o_pop_cnt != 2'd0) begin
                o_pc1     <= i_rd_pc1;
                o_ir1     <= i_rd_ir1;
                o_brinfo1 <= i_rd_brinfo1;
                o_ecode1  <= i_rd_ecode1;
            end
            if (o_pop_cnt == 2'd2) begin
                o_pc2     <= i_rd_pc2;
                o_ir2     <= i_rd_ir2;
                o_brinfo2 <= i_rd_brinfo2;
                o_ecode2  <= i_rd_ecode2;
            end
        end
    end

    // valid code follows the pop
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_is_valid <= VALID_NONE;
        end else begin
            case (o_pop_cnt)
                2'd2:    o_is_valid <= VALID_BOTH;
                2'd1:    o_is_valid <= VALID_FIRST;
                default: o_is_valid <= VALID_NONE;
            endcase
        end
    end

    a_valid_code: assert property (@(posedge clk) disable iff (!rstn)
        o_is_valid != 2'b01)
        else $error("dequeue: output valid code 01");

endmodule

/* rtl/dual_issue_ibuf.sv */
`timescale 1ns/1ps

module dual_issue_ibuf import ibuf_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    // fetch slots
    input  pc_t         i_pc1,
    input  inst_t       i_ir1,
    input  brinfo_t     i_brinfo1,
    input  ecode_t      i_ecode1,
    input  pc_t         i_pc2,
    input  inst_t       i_ir2,
    input  brinfo_t     i_brinfo2,
    input  ecode_t      i_ecode2,
    input  slot_valid_t i_is_valid,
    // branch flush and issue stall
    input  logic        i_flush,
    input  logic        i_stall,
    // decode slots
    output pc_t         o_pc1,
    output inst_t       o_ir1,
    output brinfo_t     o_brinfo1,
    output ecode_t      o_ecode1,
    output pc_t         o_pc2,
    output inst_t       o_ir2,
    output brinfo_t     o_brinfo2,
    output ecode_t      o_ecode2,
    output slot_valid_t o_is_valid,
    output logic        o_is_full
);

    // enqueue to storage
    logic      wr_en1;
    logic      wr_en2;
    ptr_t      wr_addr1;
    ptr_t      wr_addr2;
    slot_cnt_t push_cnt;

    // dequeue to storage
    ptr_t      rd_addr1;
    ptr_t      rd_addr2;
    slot_cnt_t pop_cnt;

    // storage to dequeue
    pc_t       rd_pc1;
    inst_t     rd_ir1;
    brinfo_t   rd_brinfo1;
    ecode_t    rd_ecode1;
    pc_t       rd_pc2;
    inst_t     rd_ir2;
    brinfo_t   rd_brinfo2;
    ecode_t    rd_ecode2;
    count_t    count;

    ibuf_enqueue u_enqueue (
        .clk        (clk),
        .rstn       (rstn),
        .i_is_valid (i_is_valid),
        .i_flush    (i_flush),
        .o_wr_en1   (wr_en1),
        .o_wr_en2   (wr_en2),
        .o_wr_addr1 (wr_addr1),
        .o_wr_addr2 (wr_addr2),
        .o_push_cnt (push_cnt)
    );

    // slot data go straight from the ports into storage
    ibuf_storage u_storage (
        .clk          (clk),
        .rstn         (rstn),
        .i_flush      (i_flush),
        .i_wr_en1     (wr_en1),
        .i_wr_en2     (wr_en2),
        .i_wr_addr1   (wr_addr1),
        .i_wr_addr2   (wr_addr2),
        .i_pc1        (i_pc1),
        .i_ir1        (i_ir1),
        .i_brinfo1    (i_brinfo1),
        .i_ecode1     (i_ecode1),
        .i_pc2        (i_pc2),
        .i_ir2        (i_ir2),
        .i_brinfo2    (i_brinfo2),
        .i_ecode2     (i_ecode2),
        .i_push_cnt   (push_cnt),
        .i_pop_cnt    (pop_cnt),
        .i_rd_addr1   (rd_addr1),
        .i_rd_addr2   (rd_addr2),
        .o_rd_pc1     (rd_pc1),
        .o_rd_ir1     (rd_ir1),
        .o_rd_brinfo1 (rd_brinfo1),
        .o_rd_ecode1  (rd_ecode1),
        .o_rd_pc2     (rd_pc2),
        .o_rd_ir2     (rd_ir2),
        .o_rd_brinfo2 (rd_brinfo2),
        .o_rd_ecode2  (rd_ecode2),
        .o_count      (count),
        .o_is_full    (o_is_full)
    );

    ibuf_dequeue u_dequeue (
        .clk          (clk),
        .rstn         (rstn),
        .i_flush      (i_flush),
        .i_stall      (i_stall),
        .i_count      (count),
        .i_rd_pc1     (rd_pc1),
        .i_rd_ir1     (rd_ir1),
        .i_rd_brinfo1 (rd_brinfo1),
        .i_rd_ecode1  (rd_ecode1),
        .i_rd_pc2     (rd_pc2),
        .i_rd_ir2     (rd_ir2),
        .i_rd_brinfo2 (rd_brinfo2),
        .i_rd_ecode2  (rd_ecode2),
        .o_rd_addr1   (rd_addr1),
        .o_rd_addr2   (rd_addr2),
        .o_pop_cnt    (pop_cnt),
        .o_pc1        (o_pc1),
        .o_ir1        (o_ir1),
        .o_brinfo1    (o_brinfo1),
        .o_ecode1     (o_ecode1),
        .o_pc2        (o_pc2),
        .o_ir2        (o_ir2),
        .o_brinfo2    (o_brinfo2),
        .o_ecode2     (o_ecode2),
        .o_is_valid   (o_is_valid)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rstn
);

    // 100 ns period
    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // reset low for two rising edges, released on a falling edge
    initial begin
        rstn = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

/* bench/tb_dual_issue_ibuf.sv */
`timescale 1ns/1ps

module tb_dual_issue_ibuf import ibuf_pkg::*; ();

    // one fetch slot as the model keeps it
    typedef struct packed {
        pc_t     pc;
        inst_t   ir;
        brinfo_t br;
        ecode_t  ec;
    } slot_t;

    // cycle budget per test with drains of at most depth/2 + 1 cycles
    localparam int DRAIN_MAX    = IBUF_DEPTH / 2 + 1;
    localparam int TOTAL_CYCLES = 3 + (40 + DRAIN_MAX) + (5 + 2 * DRAIN_MAX)
                                + (5 + 2 * DRAIN_MAX) + (14 + 2 * DRAIN_MAX);
    localparam int MARGIN       = 20;

    logic        clk;
    logic        rstn;
    pc_t         i_pc1;
    inst_t       i_ir1;
    brinfo_t     i_brinfo1;
    ecode_t      i_ecode1;
    pc_t         i_pc2;
    inst_t       i_ir2;
    brinfo_t     i_brinfo2;
    ecode_t      i_ecode2;
    slot_valid_t i_is_valid;
    logic        i_flush;
    logic        i_stall;
    pc_t         o_pc1;
    inst_t       o_ir1;
    brinfo_t     o_brinfo1;
    ecode_t      o_ecode1;
    pc_t         o_pc2;
    inst_t       o_ir2;
    brinfo_t     o_brinfo2;
    ecode_t      o_ecode2;
    slot_valid_t o_is_valid;
    logic        o_is_full;

    // reference model state
    slot_t       model_q[$];
    slot_t       exp1;
    slot_t       exp2;
    logic [31:0] lfsr_state;
    string       test_name;
    int          data_errors;
    int          valid_errors;
    int          full_errors;

    tb_clock u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    dual_issue_ibuf dual_issue_ibuf_inst (
        .clk        (clk),
        .rstn       (rstn),
        .i_pc1      (i_pc1),
        .i_ir1      (i_ir1),
        .i_brinfo1  (i_brinfo1),
        .i_ecode1   (i_ecode1),
        .i_pc2      (i_pc2),
        .i_ir2      (i_ir2),
        .i_brinfo2  (i_brinfo2),
        .i_ecode2   (i_ecode2),
        .i_is_valid (i_is_valid),
        .i_flush    (i_flush),
        .i_stall    (i_stall),
        .o_pc1      (o_pc1),
        .o_ir1      (o_ir1),
        .o_brinfo1  (o_brinfo1),
        .o_ecode1   (o_ecode1),
        .o_pc2      (o_pc2),
        .o_ir2      (o_ir2),
        .o_brinfo2  (o_brinfo2),
        .o_ecode2   (o_ecode2),
        .o_is_valid (o_is_valid),
        .o_is_full  (o_is_full)
    );

    //////////////////////////////////////////////////////////////////////
    // random source
    //////////////////////////////////////////////////////////////////////

    // right-shift galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // only the three legal codes
    function automatic slot_valid_t random_code();
        logic [1:0] r;
        r = 2'(take_bits(2));
        if (r == 2'd0) begin
            return VALID_NONE;
        end else if (r == 2'd1) begin
            return VALID_FIRST;
        end
        return VALID_BOTH;
    endfunction

    function automatic slot_t random_slot();
        slot_t s;
        s.pc = pc_t'(take_bits(32));
        s.ir = inst_t'(take_bits(32));
        s.br = brinfo_t'(take_bits(34));
        s.ec = ecode_t'(take_bits(8));
        return s;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_entry(input int lane, input pc_t exp_pc, input inst_t exp_ir,
                               input brinfo_t exp_br, input ecode_t exp_ec,
                               input pc_t act_pc, input inst_t act_ir,
                               input brinfo_t act_br, input ecode_t act_ec);
        if (act_pc !== exp_pc || act_ir !== exp_ir || act_br !== exp_br
                || act_ec !== exp_ec) begin
            data_errors++;
            $display("ERROR %s lane %0d: expected %h %h %h %h, actual %h %h %h %h",
                     test_name, lane, exp_pc, exp_ir, exp_br, exp_ec,
                     act_pc, act_ir, act_br, act_ec);
        end
    endtask

    task automatic check_valid(input slot_valid_t exp_v, input slot_valid_t act_v);
        if (act_v !== exp_v) begin
            valid_errors++;
            $display("ERROR %s o_is_valid: expected %b, actual %b", test_name, exp_v, act_v);
        end
    endtask

    task automatic check_full(input logic exp_f, input logic act_f);
        if (act_f !== exp_f) begin
            full_errors++;
            $display("ERROR %s o_is_full: expected %b, actual %b", test_name, exp_f, act_f);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one clock of stimulus and model
    //////////////////////////////////////////////////////////////////////

    // called on a falling edge, returns on the next one after checking
    task automatic run_cycle(input slot_valid_t code, input logic stall, input logic flush);
        slot_t       s1;
        slot_t       s2;
        int          pop;
        slot_valid_t exp_valid;
        logic        exp_full;
        s1 = random_slot();
        s2 = random_slot();
        i_pc1      = s1.pc;
        i_ir1      = s1.ir;
        i_brinfo1  = s1.br;
        i_ecode1   = s1.ec;
        i_pc2      = s2.pc;
        i_ir2      = s2.ir;
        i_brinfo2  = s2.br;
        i_ecode2   = s2.ec;
        i_is_valid = code;
        i_stall    = stall;
        i_flush    = flush;
        // pop from the count before the edge, then push
        if (flush) begin
            model_q.delete();
            pop = 0;
        end else begin
            pop = stall ? 0 : ((model_q.size() >= 2) ? 2 : model_q.size());
            if (pop >= 1) begin
                exp1 = model_q.pop_front();
            end
            if (pop == 2) begin
                exp2 = model_q.pop_front();
            end
            if (code != VALID_NONE) begin
                model_q.push_back(s1);
            end
            if (code == VALID_BOTH) begin
                model_q.push_back(s2);
            end
        end
        exp_valid = (pop == 2) ? VALID_BOTH : ((pop == 1) ? VALID_FIRST : VALID_NONE);
        exp_full  = model_q.size() >= (IBUF_DEPTH - FULL_MARGIN);
        @(posedge clk);
        @(negedge clk);
        check_valid(exp_valid, o_is_valid);
        check_full(exp_full, o_is_full);
        check_entry(1, exp1.pc, exp1.ir, exp1.br, exp1.ec, o_pc1, o_ir1, o_brinfo1, o_ecode1);
        check_entry(2, exp2.pc, exp2.ir, exp2.br, exp2.ec, o_pc2, o_ir2, o_brinfo2, o_ecode2);
    endtask

    // idle until the model queue is empty
    task automatic drain_queue();
        while (model_q.size() != 0) begin
            run_cycle(VALID_NONE, 1'b0, 1'b0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        test_name = "test_reset";
        check_valid(VALID_NONE, o_is_valid);
        check_full(1'b0, o_is_full);
        check_entry(1, '0, '0, '0, '0, o_pc1, o_ir1, o_brinfo1, o_ecode1);
        check_entry(2, '0, '0, '0, '0, o_pc2, o_ir2, o_brinfo2, o_ecode2);
    endtask

    task automatic test_stream_order();
        test_name = "test_stream_order";
        repeat (40) run_cycle(random_code(), 1'b0, 1'b0);
        drain_queue();
    endtask

    task automatic test_stall_hold();
        test_name = "test_stall_hold";
        drain_queue();
        // 9 entries stay below the almost-full threshold
        repeat (4) run_cycle(VALID_BOTH, 1'b1, 1'b0);
        run_cycle(VALID_FIRST, 1'b1, 1'b0);
        drain_queue();
    endtask

    task automatic test_almost_full();
        test_name = "test_almost_full";
        drain_queue();
        repeat (4) run_cycle(VALID_BOTH, 1'b1, 1'b0);
        check_full(1'b0, o_is_full);
        // tenth entry raises the flag
        run_cycle(VALID_BOTH, 1'b1, 1'b0);
        check_full(1'b1, o_is_full);
        // first drain leaves 8
        run_cycle(VALID_NONE, 1'b0, 1'b0);
        check_full(1'b0, o_is_full);
        drain_queue();
    endtask

    task automatic test_flush();
        test_name = "test_flush";
        drain_queue();
        // ten entries hold almost-full high before the flush
        repeat (5) run_cycle(VALID_BOTH, 1'b1, 1'b0);
        // slots offered with the flush are dropped too
        run_cycle(VALID_BOTH, 1'b0, 1'b1);
        check_valid(VALID_NONE, o_is_valid);
        check_full(1'b0, o_is_full);
        repeat (10) run_cycle(random_code(), 1'b0, 1'b0);
        drain_queue();
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        lfsr_state   = 32'ha763;
        exp1         = '0;
        exp2         = '0;
        data_errors  = 0;
        valid_errors = 0;
        full_errors  = 0;
        test_name    = "init";
        i_pc1        = '0;
        i_ir1        = '0;
        i_brinfo1    = '0;
        i_ecode1     = '0;
        i_pc2        = '0;
        i_ir2        = '0;
        i_brinfo2    = '0;
        i_ecode2     = '0;
        i_is_valid   = VALID_NONE;
        i_flush      = 1'b0;
        i_stall      = 1'b0;
        wait (rstn === 1'b1);
        @(negedge clk);
        test_reset();
        test_stream_order();
        test_stall_hold();
        test_almost_full();
        test_flush();
        $display("errors: data %0d, valid %0d, full %0d",
                 data_errors, valid_errors, full_errors);
        if (data_errors + valid_errors + full_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TOTAL_CYCLES + MARGIN) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles",
                 TOTAL_CYCLES + MARGIN);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* dual_issue_ibuf.f */
rtl/ibuf_pkg.sv
rtl/ibuf_enqueue.sv
rtl/ibuf_storage.sv
rtl/ibuf_dequeue.sv
rtl/dual_issue_ibuf.sv
bench/tb_clock.sv
bench/tb_dual_issue_ibuf.sv

/* Makefile */
TOP = tb_dual_issue_ibuf

.PHONY: compile run clean

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): dual_issue_ibuf.f rtl/*.sv bench/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f dual_issue_ibuf.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TEST FAILED" sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
